//--- common/clock_pkg.sv
`default_nettype none

package clock_pkg;

	// ----------------------------------------------------------------------
	// widths and limits
	// ----------------------------------------------------------------------
	localparam int TIME_W     = 6;	// one minutes or seconds field
	localparam int DIGIT_W    = 4;	// bcd digit
	localparam int SEG_W      = 7;
	localparam int NUM_DIGITS = 6;	// display positions

	localparam logic [TIME_W-1:0] TIME_MAX = 6'd59;	// last value before wrap

	// divider defaults, 50 MHz board clock
	localparam int SEC_DIV_DEFAULT  = 50_000_000;	// 1 Hz
	localparam int SCAN_DIV_DEFAULT = 50_000;	// 1 kHz scan step
	localparam int DB_DIV_DEFAULT   = 250_000;	// 5 ms button sample

	// ----------------------------------------------------------------------
	// modes and field positions
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SET   = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic {
		POS_SEC = 1'b0,
		POS_MIN = 1'b1
	} pos_t;

	// segment a at bit 6 down to g at bit 0, active high
	localparam logic [SEG_W-1:0] SEG_PATTERNS [10] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011	// 9
	};

	localparam logic [SEG_W-1:0] SEG_BLANK = 7'b000_0000;

endpackage

`default_nettype wire

//--- hw/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
	parameter int SEC_DIV  = clock_pkg::SEC_DIV_DEFAULT,
	parameter int SCAN_DIV = clock_pkg::SCAN_DIV_DEFAULT,
	parameter int DB_DIV   = clock_pkg::DB_DIV_DEFAULT
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_db_tick
);

	// divisors side by side, 32 bits each: sec, scan, debounce
	localparam logic [95:0] DIVS = {32'(DB_DIV), 32'(SCAN_DIV), 32'(SEC_DIV)};

	for (genvar g = 0; g < 3; g++) begin : g_div
		localparam logic [31:0] DIV = DIVS[g*32 +: 32];

		logic [31:0] cnt;
		logic        tick;	// one clk wide

		// tick comes in the DIV-th cycle, then every DIV cycles
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt  <= '0;
				tick <= 1'b0;
			end else if (cnt == DIV - 32'd1) begin
				cnt  <= '0;
				tick <= 1'b1;
			end else begin
				cnt  <= cnt + 32'd1;
				tick <= 1'b0;
			end
		end
	end

	assign o_sec_tick  = g_div[0].tick;
	assign o_scan_tick = g_div[1].tick;
	assign o_db_tick   = g_div[2].tick;

endmodule

`default_nettype wire

//--- hw/switch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module switch_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_db_tick,
	input  logic             i_btn_mode,
	input  logic             i_btn_pos,
	input  logic             i_btn_inc,
	input  logic             i_btn_alarm,
	output clock_pkg::mode_t o_mode,
	output clock_pkg::pos_t  o_pos,
	output logic             o_alarm_en,
	output logic             o_inc_pulse
);

	logic [3:0] btn;	// alarm, inc, pos, mode
	logic [3:0] smp_new;
	logic [3:0] smp_old;
	logic [3:0] stable;
	logic [3:0] stable_q;
	logic [3:0] press;

	assign btn = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	// ----------------------------------------------------------------------
	// debounce, two samples per button on the slow tick
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_new <= '0;
			smp_old <= '0;
		end else if (i_db_tick) begin
			smp_new <= btn;
			smp_old <= smp_new;
		end
	end

	assign stable = smp_new & smp_old;	// high for two samples in a row

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stable_q <= '0;
		end else begin
			stable_q <= stable;
		end
	end

	assign press = stable & ~stable_q;	// single cycle per press

	// ----------------------------------------------------------------------
	// mode, position and alarm enable state
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode      <= clock_pkg::MODE_CLOCK;
			o_pos       <= clock_pkg::POS_SEC;
			o_alarm_en  <= 1'b0;
			o_inc_pulse <= 1'b0;
		end else begin
			if (press[0]) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SET;
					clock_pkg::MODE_SET:   o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (press[1]) begin
				o_pos <= (o_pos == clock_pkg::POS_SEC) ? clock_pkg::POS_MIN
					: clock_pkg::POS_SEC;
			end
			if (press[3]) begin
				o_alarm_en <= ~o_alarm_en;	// on/off toggle
			end
			o_inc_pulse <= press[2];	// lines up with the state changes
		end
	end

endmodule

`default_nettype wire

//--- timekeep/time_counter.sv
`timescale 1ns/1ns
`default_nettype none

module time_counter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_sec_tick,
	input  clock_pkg::mode_t             i_mode,
	input  clock_pkg::pos_t              i_pos,
	input  logic                         i_inc_pulse,
	output logic [clock_pkg::TIME_W-1:0] o_sec,
	output logic [clock_pkg::TIME_W-1:0] o_min
);

	logic                         sec_last;
	logic                         min_last;
	logic [clock_pkg::TIME_W-1:0] sec_nxt;
	logic [clock_pkg::TIME_W-1:0] min_nxt;

	// next value of each field, 59 wraps to 0
	assign sec_last = (o_sec == clock_pkg::TIME_MAX);
	assign min_last = (o_min == clock_pkg::TIME_MAX);
	assign sec_nxt  = sec_last ? '0 : o_sec + 1'b1;
	assign min_nxt  = min_last ? '0 : o_min + 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
		end else if (i_mode == clock_pkg::MODE_SET) begin
			// clock stands still, button steps one field, no carry
			if (i_inc_pulse) begin
				if (i_pos == clock_pkg::POS_SEC) begin
					o_sec <= sec_nxt;
				end else begin
					o_min <= min_nxt;
				end
			end
		end else if (i_sec_tick) begin
			o_sec <= sec_nxt;
			if (sec_last) begin
				o_min <= min_nxt;	// carry on the same tick
			end
		end
	end

endmodule

`default_nettype wire

//--- timekeep/alarm_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alarm_unit (
	input  logic                         clk,
	input  logic                         rst_n,
	input  clock_pkg::mode_t             i_mode,
	input  clock_pkg::pos_t              i_pos,
	input  logic                         i_inc_pulse,
	input  logic                         i_alarm_en,
	input  logic [clock_pkg::TIME_W-1:0] i_sec,
	input  logic [clock_pkg::TIME_W-1:0] i_min,
	output logic [clock_pkg::TIME_W-1:0] o_alm_sec,
	output logic [clock_pkg::TIME_W-1:0] o_alm_min,
	output logic                         o_alarm
);

	logic                         step;
	logic                         hit;
	logic [clock_pkg::TIME_W-1:0] alm_sec_nxt;
	logic [clock_pkg::TIME_W-1:0] alm_min_nxt;

	assign step        = i_inc_pulse && (i_mode == clock_pkg::MODE_ALARM);
	assign alm_sec_nxt = (o_alm_sec == clock_pkg::TIME_MAX) ? '0 : o_alm_sec + 1'b1;
	assign alm_min_nxt = (o_alm_min == clock_pkg::TIME_MAX) ? '0 : o_alm_min + 1'b1;

	// ----------------------------------------------------------------------
	// alarm time registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alm_sec <= '0;
			o_alm_min <= '0;
		end else if (step) begin
			if (i_pos == clock_pkg::POS_SEC) begin
				o_alm_sec <= alm_sec_nxt;
			end else begin
				o_alm_min <= alm_min_nxt;
			end
		end
	end

	// clock time meets alarm time
	assign hit = (i_sec == o_alm_sec) && (i_min == o_alm_min);

	// latched until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (hit | o_alarm);
		end
	end

endmodule

`default_nettype wire

//--- display/seg_display.sv
`timescale 1ns/1ns
`default_nettype none

module seg_display (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_scan_tick,
	input  clock_pkg::mode_t                 i_mode,
	input  logic [clock_pkg::TIME_W-1:0]     i_sec,
	input  logic [clock_pkg::TIME_W-1:0]     i_min,
	input  logic [clock_pkg::TIME_W-1:0]     i_alm_sec,
	input  logic [clock_pkg::TIME_W-1:0]     i_alm_min,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	logic [clock_pkg::TIME_W-1:0]               show_sec;
	logic [clock_pkg::TIME_W-1:0]               show_min;
	logic [clock_pkg::DIGIT_W-1:0]              sec_ones;
	logic [clock_pkg::DIGIT_W-1:0]              sec_tens;
	logic [clock_pkg::DIGIT_W-1:0]              min_ones;
	logic [clock_pkg::DIGIT_W-1:0]              min_tens;
	logic [$clog2(clock_pkg::NUM_DIGITS)-1:0]   scan_idx;
	logic [clock_pkg::SEG_W-1:0]                seg_nxt;
	logic [clock_pkg::NUM_DIGITS-1:0]           enb_nxt;

	// ----------------------------------------------------------------------
	// time source and tens/units split
	// ----------------------------------------------------------------------
	assign show_sec = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_sec : i_sec;
	assign show_min = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_min : i_min;

	assign sec_ones = clock_pkg::DIGIT_W'(show_sec % 10);
	assign sec_tens = clock_pkg::DIGIT_W'(show_sec / 10);
	assign min_ones = clock_pkg::DIGIT_W'(show_min % 10);
	assign min_tens = clock_pkg::DIGIT_W'(show_min / 10);

	// ----------------------------------------------------------------------
	// scan position 0..5
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == clock_pkg::NUM_DIGITS - 1) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	// digit for the current position, upper two stay dark
	always_comb begin
		case (scan_idx)
			3'd0:    seg_nxt = clock_pkg::SEG_PATTERNS[sec_ones];
			3'd1:    seg_nxt = clock_pkg::SEG_PATTERNS[sec_tens];
			3'd2:    seg_nxt = clock_pkg::SEG_PATTERNS[min_ones];
			3'd3:    seg_nxt = clock_pkg::SEG_PATTERNS[min_tens];
			default: seg_nxt = clock_pkg::SEG_BLANK;
		endcase
	end

	assign enb_nxt = ~(clock_pkg::NUM_DIGITS'(1) << scan_idx);	// common cathode, low = on

	// pattern and enable leave in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= clock_pkg::SEG_PATTERNS[0];
			o_seg_enb <= ~clock_pkg::NUM_DIGITS'(1);
		end else begin
			o_seg     <= seg_nxt;
			o_seg_enb <= enb_nxt;
		end
	end

endmodule

`default_nettype wire

//--- hw/digital_clock_top.sv
`timescale 1ns/1ns
`default_nettype none

module digital_clock_top #(
	parameter int SEC_DIV  = clock_pkg::SEC_DIV_DEFAULT,
	parameter int SCAN_DIV = clock_pkg::SCAN_DIV_DEFAULT,
	parameter int DB_DIV   = clock_pkg::DB_DIV_DEFAULT
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_btn_mode,
	input  logic                             i_btn_pos,
	input  logic                             i_btn_inc,
	input  logic                             i_btn_alarm,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                             o_alarm
);

	logic                         sec_tick;
	logic                         scan_tick;
	logic                         db_tick;
	clock_pkg::mode_t             mode;
	clock_pkg::pos_t              pos;
	logic                         alarm_en;
	logic                         inc_pulse;
	logic [clock_pkg::TIME_W-1:0] clk_sec;
	logic [clock_pkg::TIME_W-1:0] clk_min;
	logic [clock_pkg::TIME_W-1:0] alm_sec;
	logic [clock_pkg::TIME_W-1:0] alm_min;

	tick_gen #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV),
		.DB_DIV   (DB_DIV)
	) u_tick (
		.clk         (clk),
		.rst_n       (rst_n),
		.o_sec_tick  (sec_tick),
		.o_scan_tick (scan_tick),
		.o_db_tick   (db_tick)
	);

	switch_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_db_tick   (db_tick),
		.i_btn_mode  (i_btn_mode),
		.i_btn_pos   (i_btn_pos),
		.i_btn_inc   (i_btn_inc),
		.i_btn_alarm (i_btn_alarm),
		.o_mode      (mode),
		.o_pos       (pos),
		.o_alarm_en  (alarm_en),
		.o_inc_pulse (inc_pulse)
	);

	// running clock
	time_counter u_time (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_inc_pulse (inc_pulse),
		.o_sec       (clk_sec),
		.o_min       (clk_min)
	);

	alarm_unit u_alarm (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_inc_pulse (inc_pulse),
		.i_alarm_en  (alarm_en),
		.i_sec       (clk_sec),
		.i_min       (clk_min),
		.o_alm_sec   (alm_sec),
		.o_alm_min   (alm_min),
		.o_alarm     (o_alarm)
	);

	seg_display u_disp (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_mode      (mode),
		.i_sec       (clk_sec),
		.i_min       (clk_min),
		.i_alm_sec   (alm_sec),
		.i_alm_min   (alm_min),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

`default_nettype wire

//--- tests/tb_digital_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_digital_clock;

	localparam int SEC_DIV     = 20;
	localparam int SCAN_DIV    = 4;
	localparam int DB_DIV      = 3;
	localparam int CLK_PERIOD  = 40;
	localparam int HOLD_CYC    = 12;	// cycles held for a press and again for its release
	localparam int LEAD_SEC    = 12;	// clock set this far behind the alarm
	localparam int LAST        = 59;
	localparam int PRESS_CYC   = 2 * SEC_DIV + 4;	// worst case with alignment
	localparam int RUN_CYC     = 131 * SEC_DIV + 360 * PRESS_CYC + 60 * SEC_DIV;
	localparam int WATCHDOG_NS = (RUN_CYC + 4000) * CLK_PERIOD;

	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	// a..g from bit 6 down and active high
	localparam logic [6:0] SEG_TABLE [10] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73
	};

	logic                             clk;
	logic                             rst_n;
	logic                             btn_mode;
	logic                             btn_pos;
	logic                             btn_inc;
	logic                             btn_alarm;
	logic [clock_pkg::SEG_W-1:0]      seg;
	logic [clock_pkg::NUM_DIGITS-1:0] seg_enb;
	logic                             alarm;

	// reference model
	clock_pkg::mode_t m_mode;
	clock_pkg::pos_t  m_pos;
	logic             m_alarm_en;
	logic             m_alarm;
	int               m_sec;
	int               m_min;
	int               m_alm_sec;
	int               m_alm_min;
	int               shown_sec;	// value behind o_seg after the last edge
	int               shown_min;
	int               cyc;	// rising edges since reset release

	logic [31:0] seed;
	int          checks;
	int          errors;
	int          tests;

	digital_clock_top #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV),
		.DB_DIV   (DB_DIV)
	) digital_clock_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_mode),
		.i_btn_pos   (btn_pos),
		.i_btn_inc   (btn_inc),
		.i_btn_alarm (btn_alarm),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// model timing with seconds stepping on the edge after each tick
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
			if (m_mode == clock_pkg::MODE_ALARM) begin
				shown_sec = m_alm_sec;
				shown_min = m_alm_min;
			end else begin
				shown_sec = m_sec;
				shown_min = m_min;
			end
			m_alarm = m_alarm_en && ((m_sec == m_alm_sec && m_min == m_alm_min) || m_alarm);
			if (cyc % SEC_DIV == 0 && cyc != 0 && m_mode != clock_pkg::MODE_SET) begin
				if (m_sec == LAST) begin
					m_sec = 0;
					m_min = wrap_inc(m_min);	// carry
				end else begin
					m_sec = m_sec + 1;
				end
			end
		end
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int next_rand(input int lo, input int hi);
		seed = lcg_step(seed);
		return lo + int'((seed >> 8) % 32'(hi - lo + 1));
	endfunction

	function automatic int wrap_inc(input int v);
		return (v == LAST) ? 0 : v + 1;
	endfunction

	function automatic int decode_seg(input logic [6:0] s);
		int d;
		d = (s == 7'h00) ? 15 : 14;	// 15 for blank and 14 for garbage
		for (int i = 0; i < 10; i++) begin
			if (s == SEG_TABLE[i]) d = i;
		end
		return d;
	endfunction

	function automatic int expected_digit(input int idx, input int secs, input int mins);
		case (idx)
			0:       return secs % 10;
			1:       return secs / 10;
			2:       return mins % 10;
			3:       return mins / 10;
			default: return 15;
		endcase
	endfunction

	// position of the single low enable bit or -1
	function automatic int low_index(input logic [5:0] enb);
		int n;
		int p;
		n = 0;
		p = -1;
		for (int i = 0; i < 6; i++) begin
			if (enb[i] == 1'b0) begin
				n++;
				p = i;
			end
		end
		return (n == 1) ? p : -1;
	endfunction

	task automatic fail_value(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		tests++;
		if (errors == err_before) $display("test %0d %s: ok", num, name);
		else $display("test %0d %s: %0d errors", num, name, errors - err_before);
	endtask

	task automatic set_button(input int which, input logic level);
		case (which)
			BTN_MODE: btn_mode <= level;
			BTN_POS:  btn_pos <= level;
			BTN_INC:  btn_inc <= level;
			default:  btn_alarm <= level;
		endcase
	endtask

	task automatic apply_press(input int which);
		case (which)
			BTN_MODE: begin
				if (m_mode == clock_pkg::MODE_CLOCK) m_mode = clock_pkg::MODE_SET;
				else if (m_mode == clock_pkg::MODE_SET) m_mode = clock_pkg::MODE_ALARM;
				else m_mode = clock_pkg::MODE_CLOCK;
			end
			BTN_POS: begin
				if (m_pos == clock_pkg::POS_SEC) m_pos = clock_pkg::POS_MIN;
				else m_pos = clock_pkg::POS_SEC;
			end
			BTN_INC: begin
				if (m_mode == clock_pkg::MODE_SET) begin
					if (m_pos == clock_pkg::POS_SEC) m_sec = wrap_inc(m_sec);
					else m_min = wrap_inc(m_min);
				end else if (m_mode == clock_pkg::MODE_ALARM) begin
					if (m_pos == clock_pkg::POS_SEC) m_alm_sec = wrap_inc(m_alm_sec);
					else m_alm_min = wrap_inc(m_alm_min);
				end
			end
			default: m_alarm_en = !m_alarm_en;
		endcase
	endtask

	// edge on which the counter takes a second tick
	task automatic wait_tick_edge();
		@(posedge clk);
		while (cyc % SEC_DIV != 0 || cyc == 0) @(posedge clk);
	endtask

	// press starts on a tick edge so the effect lands well before the next tick
	task automatic press_button(input int which);
		wait_tick_edge();
		set_button(which, 1'b1);
		repeat (HOLD_CYC) @(posedge clk);
		set_button(which, 1'b0);
		@(negedge clk);
		apply_press(which);
		repeat (HOLD_CYC) @(posedge clk);
	endtask

	task automatic goto_mode(input clock_pkg::mode_t target);
		while (m_mode != target) press_button(BTN_MODE);
	endtask

	task automatic select_pos(input clock_pkg::pos_t target);
		if (m_pos != target) press_button(BTN_POS);
	endtask

	// ------------------------------------------------------------------
	// display reader with one check per sampled digit
	// ------------------------------------------------------------------
	task automatic read_display();
		logic [5:0] seen;
		int         idx;
		int         got;
		int         exp;
		int         waited;
		seen = '0;
		waited = 0;
		while (seen != 6'h3f && waited < 4 * 6 * SCAN_DIV) begin
			@(negedge clk);
			waited++;
			idx = low_index(seg_enb);
			checks++;
			if (idx < 0) begin
				fail_value($sformatf("enable %b has not exactly one low bit", seg_enb));
			end else begin
				got = decode_seg(seg);
				exp = expected_digit(idx, shown_sec, shown_min);
				if (got != exp) begin
					fail_value($sformatf("digit %0d reads %0d, expected %0d", idx, got, exp));
				end
				seen[idx] = 1'b1;
			end
			if (alarm !== m_alarm) fail_value($sformatf("o_alarm is %b", alarm));
		end
		if (seen != 6'h3f) begin
			$display("display scan did not visit all six digits, seen %b", seen);
			errors++;
		end
	endtask

	// digits shown while the counter holds the given number of seconds since reset
	task automatic check_window(input int total);
		int idx;
		int got;
		int exp;
		while (cyc < total * SEC_DIV + 2) @(negedge clk);
		while (cyc < (total + 1) * SEC_DIV + 2) begin
			idx = low_index(seg_enb);
			checks++;
			if (idx >= 0) begin
				got = decode_seg(seg);
				exp = expected_digit(idx, total % 60, total / 60);
				if (got != exp) begin
					fail_value($sformatf("digit %0d reads %0d after %0d s, expected %0d",
						idx, got, total, exp));
				end
			end
			@(negedge clk);
		end
	endtask

	task automatic watch_alarm(input int cycles);
		int bad;
		bad = 0;
		repeat (cycles) begin
			@(negedge clk);
			checks++;
			if (alarm !== m_alarm) begin
				if (bad == 0) fail_value($sformatf("o_alarm %b, expected %b", alarm, m_alarm));
				else errors++;
				bad++;
			end
		end
	endtask

	// clock set LEAD_SEC behind the alarm and watched past the alarm time
	task automatic alarm_round(input logic enable);
		int target;
		int n;
		goto_mode(clock_pkg::MODE_SET);
		target = (m_alm_min * 60 + m_alm_sec - LEAD_SEC + 3600) % 3600;
		select_pos(clock_pkg::POS_SEC);
		n = (target % 60 - m_sec + 60) % 60;
		repeat (n) press_button(BTN_INC);
		select_pos(clock_pkg::POS_MIN);
		n = (target / 60 - m_min + 60) % 60;
		repeat (n) press_button(BTN_INC);
		goto_mode(clock_pkg::MODE_CLOCK);
		if (enable) press_button(BTN_ALARM);
		watch_alarm((LEAD_SEC + 2) * SEC_DIV);
		checks++;
		if (alarm !== enable) fail_value($sformatf("o_alarm %b after alarm time", alarm));
		if (enable) begin
			press_button(BTN_ALARM);
			checks++;
			if (alarm !== 1'b0) fail_value("o_alarm still high after disable");
			watch_alarm(2 * SEC_DIV);
		end
	endtask

	initial begin
		int k;
		int n;
		int err0;
		rst_n      = 1'b0;
		btn_mode   = 1'b0;
		btn_pos    = 1'b0;
		btn_inc    = 1'b0;
		btn_alarm  = 1'b0;
		seed       = 32'hc08f;
		m_mode     = clock_pkg::MODE_CLOCK;
		m_pos      = clock_pkg::POS_SEC;
		m_alarm_en = 1'b0;
		m_alarm    = 1'b0;
		m_sec      = 0;
		m_min      = 0;
		m_alm_sec  = 0;
		m_alm_min  = 0;
		shown_sec  = 0;
		shown_min  = 0;
		checks     = 0;
		errors     = 0;
		tests      = 0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		err0 = errors;
		@(negedge clk);
		checks++;
		if (alarm !== 1'b0) fail_value("o_alarm not low after reset");
		read_display();
		report_test(1, "reset state", err0);

		// free running for k seconds after reset
		err0 = errors;
		k = next_rand(61, 130);
		check_window(k);
		read_display();
		report_test(2, "free running", err0);

		err0 = errors;
		goto_mode(clock_pkg::MODE_SET);
		select_pos(clock_pkg::POS_SEC);
		n = (60 - m_sec) + next_rand(0, 3);	// always crosses 59
		repeat (n) press_button(BTN_INC);
		select_pos(clock_pkg::POS_MIN);
		n = next_rand(1, 5);
		repeat (n) press_button(BTN_INC);
		read_display();
		repeat (3 * SEC_DIV) @(posedge clk);
		read_display();	// still frozen
		goto_mode(clock_pkg::MODE_CLOCK);
		report_test(3, "set mode", err0);

		err0 = errors;
		goto_mode(clock_pkg::MODE_ALARM);
		n = next_rand(1, 6);
		repeat (n) press_button(BTN_INC);
		select_pos(clock_pkg::POS_SEC);
		n = next_rand(3, 20);
		repeat (n) press_button(BTN_INC);
		read_display();
		repeat (3 * SEC_DIV) @(posedge clk);
		goto_mode(clock_pkg::MODE_CLOCK);
		read_display();	// clock kept running underneath
		report_test(4, "alarm setting", err0);

		err0 = errors;
		alarm_round(1'b0);
		alarm_round(1'b1);
		report_test(5, "alarm firing", err0);

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) $display("ALL CHECKS PASSED");
		else $display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
common/clock_pkg.sv
hw/tick_gen.sv
hw/switch_ctrl.sv
timekeep/time_counter.sv
timekeep/alarm_unit.sv
display/seg_display.sv
hw/digital_clock_top.sv
tests/tb_digital_clock.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_digital_clock -f files.f -o sim \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }
